//--- source/cl_fsb_settings.svh
// Shell control path settings
// Bus widths, reset pipe depth, host slot map and the PCI ID words
// shared by the packages and the RTL blocks

`ifndef CL_FSB_SETTINGS_SVH
`define CL_FSB_SETTINGS_SVH

// host AXI-lite bus (OCL)
`define OCL_ADDR_W      32
`define OCL_DATA_W      32

// slot map, four 4 KiB windows selected by address bits 13:12
`define OCL_SLOT_OFS_W  12
`define OCL_SLOT_W      2

// flops between the shell reset and the block reset synchronizer
`define RST_PIPE_STAGES 4

// PCI ID words reported to the shell
`define CL_SH_ID0       32'hF001_1D0F
`define CL_SH_ID1       32'h1D51_FEDC

`endif

//--- source/ocl_bus_pkg.sv
// OCL host bus types
// AXI-lite payload words, response codes, slot numbers and the
// address word with its slot/offset view

package ocl_bus_pkg;

  `include "cl_fsb_settings.svh"

  typedef logic [`OCL_ADDR_W-1:0]   ocl_addr_t;
  typedef logic [`OCL_DATA_W-1:0]   ocl_data_t;
  typedef logic [`OCL_DATA_W/8-1:0] ocl_strb_t;

  // bresp / rresp codes without EXOKAY
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } axil_resp_e;

  // targets behind the host bus
  typedef enum logic [`OCL_SLOT_W-1:0] {
    SLOT_CTRL = 0,
    SLOT_FSB  = 1,
    SLOT_PCIM = 2,
    SLOT_AXIS = 3
  } ocl_slot_e;

  typedef struct packed {
    logic [`OCL_ADDR_W-`OCL_SLOT_W-`OCL_SLOT_OFS_W-1:0] unused;
    ocl_slot_e                                         slot;
    logic [`OCL_SLOT_OFS_W-1:0]                        offset;
  } ocl_addr_fields_t;

  // router decodes the slot and the register block the offset
  typedef union packed {
    ocl_addr_t        raw;
    ocl_addr_fields_t f;
  } ocl_addr_u;

endpackage

//--- source/cl_ctrl_pkg.sv
// Control register map of slot 0
// Word indices of the ID and scratch registers and the scratch
// register number

package cl_ctrl_pkg;

  `include "cl_fsb_settings.svh"

  // word index, offset bits 11:2
  typedef enum logic [`OCL_SLOT_OFS_W-3:0] {
    REG_ID0      = 0,
    REG_ID1      = 1,
    REG_SCRATCH0 = 4,
    REG_SCRATCH1 = 5,
    REG_SCRATCH2 = 6,
    REG_SCRATCH3 = 7
  } ctrl_reg_e;

  // scratch number, low two bits of the word index
  typedef logic [1:0] scratch_idx_t;

endpackage

//--- source/cl_reset_ctrl.sv
// Reset fan-out and FLR acknowledge
// Delays the shell reset through a flop pipe, then through a two-flop
// synchronizer into the block reset. Answers FLR with a done pulse.

`timescale 1ns/1ns

`include "cl_fsb_settings.svh"

module cl_reset_ctrl #(
  parameter int unsigned STAGES = `RST_PIPE_STAGES
) (
  input  logic clk_main_a0,
  input  logic pipe_rst_n,
  input  logic sh_cl_flr_assert_i,
  output logic ocl_rst_n_o,
  output logic cl_sh_flr_done_o
);

  logic [STAGES-1:0] pipe_q;
  logic [1:0]        sync_q;
  logic              flr_assert_q;
  logic              flr_done_q;

  // --------------------------------------------------------------------------
  // reset pipe, ones shift in once the shell reset is released
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!pipe_rst_n)
    begin
      pipe_q <= '0;
    end
    else
    begin
      pipe_q[0] <= 1'b1;
      for (int i = 1; i < STAGES; i++)
        pipe_q[i] <= pipe_q[i-1];
    end
  end

  // synchronizer held in reset by the pipe tail
  always_ff @(posedge clk_main_a0)
  begin
    if (!pipe_q[STAGES-1])
      sync_q <= 2'b00;
    else
      sync_q <= {sync_q[0], 1'b1};
  end

  assign ocl_rst_n_o = sync_q[1];

  // --------------------------------------------------------------------------
  // FLR response
  // --------------------------------------------------------------------------
  // done toggles while the registered assert stays high
  always_ff @(posedge clk_main_a0)
  begin
    if (!sync_q[1])
    begin
      flr_assert_q <= 1'b0;
      flr_done_q   <= 1'b0;
    end
    else
    begin
      flr_assert_q <= sh_cl_flr_assert_i;
      flr_done_q   <= flr_assert_q && !flr_done_q;
    end
  end

  assign cl_sh_flr_done_o = flr_done_q;

endmodule

//--- source/ocl_slot_router.sv
// OCL slot router
// AXI-lite slave for the host bus. Decodes the slot of each access,
// runs a req/ack handshake to the register block for slot 0 and
// answers the other slots with DECERR. One write and one read in flight.

`timescale 1ns/1ns

module ocl_slot_router
  import ocl_bus_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       ocl_rst_n_i,
  // host AXI-lite
  input  logic       sh_ocl_awvalid_i,
  input  ocl_addr_t  sh_ocl_awaddr_i,
  output logic       ocl_sh_awready_o,
  input  logic       sh_ocl_wvalid_i,
  input  ocl_data_t  sh_ocl_wdata_i,
  input  ocl_strb_t  sh_ocl_wstrb_i,
  output logic       ocl_sh_wready_o,
  output logic       ocl_sh_bvalid_o,
  output axil_resp_e ocl_sh_bresp_o,
  input  logic       sh_ocl_bready_i,
  input  logic       sh_ocl_arvalid_i,
  input  ocl_addr_t  sh_ocl_araddr_i,
  output logic       ocl_sh_arready_o,
  output logic       ocl_sh_rvalid_o,
  output ocl_data_t  ocl_sh_rdata_o,
  output axil_resp_e ocl_sh_rresp_o,
  input  logic       sh_ocl_rready_i,
  // register block, write pair
  output logic       wr_req_o,
  output ocl_addr_u  wr_addr_o,
  output ocl_data_t  wr_data_o,
  output ocl_strb_t  wr_strb_o,
  input  logic       wr_ack_i,
  input  axil_resp_e wr_resp_i,
  // register block, read pair
  output logic       rd_req_o,
  output ocl_addr_u  rd_addr_o,
  input  logic       rd_ack_i,
  input  ocl_data_t  rd_data_i,
  input  axil_resp_e rd_resp_i
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_REL  = 2'd2;
  localparam logic [1:0] ST_RESP = 2'd3;

  logic [1:0] wr_state_q;
  logic [1:0] rd_state_q;
  logic       wr_accept;
  logic       rd_accept;
  ocl_addr_u  aw_dec;
  ocl_addr_u  ar_dec;
  ocl_addr_u  wr_addr_q;
  ocl_data_t  wr_data_q;
  ocl_strb_t  wr_strb_q;
  axil_resp_e bresp_q;
  ocl_addr_u  rd_addr_q;
  ocl_data_t  rdata_q;
  axil_resp_e rresp_q;

  assign aw_dec.raw = sh_ocl_awaddr_i;
  assign ar_dec.raw = sh_ocl_araddr_i;

  // --------------------------------------------------------------------------
  // write channel
  // --------------------------------------------------------------------------
  // address and data taken together, only when idle
  assign wr_accept        = (wr_state_q == ST_IDLE) && sh_ocl_awvalid_i && sh_ocl_wvalid_i;
  assign ocl_sh_awready_o = wr_accept;
  assign ocl_sh_wready_o  = wr_accept;

  always_ff @(posedge clk_main_a0)
  begin
    if (!ocl_rst_n_i)
    begin
      wr_state_q <= ST_IDLE;
    end
    else
    begin
      case (wr_state_q)
        ST_IDLE:
          if (wr_accept)
            wr_state_q <= (aw_dec.f.slot == SLOT_CTRL) ? ST_REQ : ST_RESP;
        ST_REQ:
          if (wr_ack_i)
            wr_state_q <= ST_REL;
        ST_REL:
          if (!wr_ack_i)
            wr_state_q <= ST_RESP;
        default:
          if (sh_ocl_bready_i)
            wr_state_q <= ST_IDLE;
      endcase
    end
  end

  // decode miss keeps DECERR, slot 0 takes the block's answer
  always_ff @(posedge clk_main_a0)
  begin
    if (wr_accept)
    begin
      wr_addr_q <= aw_dec;
      wr_data_q <= sh_ocl_wdata_i;
      wr_strb_q <= sh_ocl_wstrb_i;
      bresp_q   <= DECERR;
    end
    else if ((wr_state_q == ST_REQ) && wr_ack_i)
    begin
      bresp_q <= wr_resp_i;
    end
  end

  assign wr_req_o        = (wr_state_q == ST_REQ);
  assign wr_addr_o       = wr_addr_q;
  assign wr_data_o       = wr_data_q;
  assign wr_strb_o       = wr_strb_q;
  assign ocl_sh_bvalid_o = (wr_state_q == ST_RESP);
  assign ocl_sh_bresp_o  = bresp_q;

  // --------------------------------------------------------------------------
  // read channel
  // --------------------------------------------------------------------------
  assign rd_accept        = (rd_state_q == ST_IDLE) && sh_ocl_arvalid_i;
  assign ocl_sh_arready_o = rd_accept;

  always_ff @(posedge clk_main_a0)
  begin
    if (!ocl_rst_n_i)
    begin
      rd_state_q <= ST_IDLE;
    end
    else
    begin
      case (rd_state_q)
        ST_IDLE:
          if (rd_accept)
            rd_state_q <= (ar_dec.f.slot == SLOT_CTRL) ? ST_REQ : ST_RESP;
        ST_REQ:
          if (rd_ack_i)
            rd_state_q <= ST_REL;
        ST_REL:
          if (!rd_ack_i)
            rd_state_q <= ST_RESP;
        default:
          if (sh_ocl_rready_i)
            rd_state_q <= ST_IDLE;
      endcase
    end
  end

  // read data captured on ack, zero on a decode miss
  always_ff @(posedge clk_main_a0)
  begin
    if (rd_accept)
    begin
      rd_addr_q <= ar_dec;
      rdata_q   <= '0;
      rresp_q   <= DECERR;
    end
    else if ((rd_state_q == ST_REQ) && rd_ack_i)
    begin
      rdata_q <= rd_data_i;
      rresp_q <= rd_resp_i;
    end
  end

  assign rd_req_o        = (rd_state_q == ST_REQ);
  assign rd_addr_o       = rd_addr_q;
  assign ocl_sh_rvalid_o = (rd_state_q == ST_RESP);
  assign ocl_sh_rdata_o  = rdata_q;
  assign ocl_sh_rresp_o  = rresp_q;

endmodule

//--- source/ocl_ctrl_regs.sv
// Control register block behind slot 0
// Returns the two PCI ID words and holds four byte-writable scratch
// registers. Served over the write and read req/ack pairs.

`timescale 1ns/1ns

`include "cl_fsb_settings.svh"

module ocl_ctrl_regs
  import ocl_bus_pkg::*;
  import cl_ctrl_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       ocl_rst_n_i,
  input  logic       wr_req_i,
  input  ocl_addr_u  wr_addr_i,
  input  ocl_data_t  wr_data_i,
  input  ocl_strb_t  wr_strb_i,
  output logic       wr_ack_o,
  output axil_resp_e wr_resp_o,
  input  logic       rd_req_i,
  input  ocl_addr_u  rd_addr_i,
  output logic       rd_ack_o,
  output ocl_data_t  rd_data_o,
  output axil_resp_e rd_resp_o
);

  localparam int unsigned NUM_SCRATCH = 2 ** $bits(scratch_idx_t);

  ctrl_reg_e    wr_reg;
  ctrl_reg_e    rd_reg;
  scratch_idx_t wr_idx;
  scratch_idx_t rd_idx;
  logic         wr_hit;
  logic         wr_scr;
  logic         rd_hit;
  ocl_data_t    rd_val;
  logic         wr_ack_q;
  logic         rd_ack_q;
  axil_resp_e   wr_resp_q;
  ocl_data_t    rd_data_q;
  axil_resp_e   rd_resp_q;
  ocl_data_t    scratch_q [NUM_SCRATCH];

  // word index from the offset half of the address
  assign wr_reg = ctrl_reg_e'(wr_addr_i.f.offset[`OCL_SLOT_OFS_W-1:2]);
  assign rd_reg = ctrl_reg_e'(rd_addr_i.f.offset[`OCL_SLOT_OFS_W-1:2]);
  assign wr_idx = wr_addr_i.f.offset[3:2];
  assign rd_idx = rd_addr_i.f.offset[3:2];

  // ID words are read only, writes to them are dropped
  always_comb
  begin
    wr_hit = 1'b1;
    wr_scr = 1'b0;
    case (wr_reg)
      REG_ID0, REG_ID1: wr_scr = 1'b0;
      REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3: wr_scr = 1'b1;
      default: wr_hit = 1'b0;
    endcase
  end

  always_comb
  begin
    rd_hit = 1'b1;
    rd_val = '0;
    case (rd_reg)
      REG_ID0: rd_val = `CL_SH_ID0;
      REG_ID1: rd_val = `CL_SH_ID1;
      REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3: rd_val = scratch_q[rd_idx];
      default: rd_hit = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // four-phase handshake, ack follows req one cycle later
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!ocl_rst_n_i)
    begin
      wr_ack_q <= 1'b0;
      rd_ack_q <= 1'b0;
      for (int i = 0; i < NUM_SCRATCH; i++)
        scratch_q[i] <= '0;
    end
    else
    begin
      wr_ack_q <= wr_req_i;
      rd_ack_q <= rd_req_i;
      // byte lanes gated by the strobes
      if (wr_req_i && !wr_ack_q && wr_scr)
        for (int b = 0; b < $bits(ocl_strb_t); b++)
          if (wr_strb_i[b])
            scratch_q[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (wr_req_i && !wr_ack_q)
      wr_resp_q <= wr_hit ? OKAY : SLVERR;
    if (rd_req_i && !rd_ack_q)
    begin
      rd_data_q <= rd_val;
      rd_resp_q <= rd_hit ? OKAY : SLVERR;
    end
  end

  assign wr_ack_o  = wr_ack_q;
  assign wr_resp_o = wr_resp_q;
  assign rd_ack_o  = rd_ack_q;
  assign rd_data_o = rd_data_q;
  assign rd_resp_o = rd_resp_q;

endmodule

//--- source/cl_fsb.sv
// Custom logic shell control path, top level
// Reset fan-out, FLR acknowledge and host register access over the
// OCL AXI-lite bus, with slot 0 served by the control registers

`timescale 1ns/1ns

`include "cl_fsb_settings.svh"

module cl_fsb
  import ocl_bus_pkg::*;
(
  input  logic        clk_main_a0,
  input  logic        pipe_rst_n,
  input  logic        sh_cl_flr_assert_i,
  output logic        cl_sh_flr_done_o,
  output logic [31:0] cl_sh_id0_o,
  output logic [31:0] cl_sh_id1_o,
  // OCL host bus
  input  logic        sh_ocl_awvalid_i,
  input  ocl_addr_t   sh_ocl_awaddr_i,
  output logic        ocl_sh_awready_o,
  input  logic        sh_ocl_wvalid_i,
  input  ocl_data_t   sh_ocl_wdata_i,
  input  ocl_strb_t   sh_ocl_wstrb_i,
  output logic        ocl_sh_wready_o,
  output logic        ocl_sh_bvalid_o,
  output axil_resp_e  ocl_sh_bresp_o,
  input  logic        sh_ocl_bready_i,
  input  logic        sh_ocl_arvalid_i,
  input  ocl_addr_t   sh_ocl_araddr_i,
  output logic        ocl_sh_arready_o,
  output logic        ocl_sh_rvalid_o,
  output ocl_data_t   ocl_sh_rdata_o,
  output axil_resp_e  ocl_sh_rresp_o,
  input  logic        sh_ocl_rready_i
);

  logic       ocl_rst_n;
  logic       wr_req;
  ocl_addr_u  wr_addr;
  ocl_data_t  wr_data;
  ocl_strb_t  wr_strb;
  logic       wr_ack;
  axil_resp_e wr_resp;
  logic       rd_req;
  ocl_addr_u  rd_addr;
  logic       rd_ack;
  ocl_data_t  rd_data;
  axil_resp_e rd_resp;

  // PCI IDs
  assign cl_sh_id0_o = `CL_SH_ID0;
  assign cl_sh_id1_o = `CL_SH_ID1;

  // --------------------------------------------------------------------------
  // reset and FLR
  // --------------------------------------------------------------------------
  cl_reset_ctrl #(
    .STAGES(`RST_PIPE_STAGES)
  ) u_reset_ctrl (
    .clk_main_a0       (clk_main_a0),
    .pipe_rst_n        (pipe_rst_n),
    .sh_cl_flr_assert_i(sh_cl_flr_assert_i),
    .ocl_rst_n_o       (ocl_rst_n),
    .cl_sh_flr_done_o  (cl_sh_flr_done_o)
  );

  // --------------------------------------------------------------------------
  // host bus slot router and slot 0 registers
  // --------------------------------------------------------------------------
  ocl_slot_router u_slot_router (
    .clk_main_a0     (clk_main_a0),
    .ocl_rst_n_i     (ocl_rst_n),
    .sh_ocl_awvalid_i(sh_ocl_awvalid_i),
    .sh_ocl_awaddr_i (sh_ocl_awaddr_i),
    .ocl_sh_awready_o(ocl_sh_awready_o),
    .sh_ocl_wvalid_i (sh_ocl_wvalid_i),
    .sh_ocl_wdata_i  (sh_ocl_wdata_i),
    .sh_ocl_wstrb_i  (sh_ocl_wstrb_i),
    .ocl_sh_wready_o (ocl_sh_wready_o),
    .ocl_sh_bvalid_o (ocl_sh_bvalid_o),
    .ocl_sh_bresp_o  (ocl_sh_bresp_o),
    .sh_ocl_bready_i (sh_ocl_bready_i),
    .sh_ocl_arvalid_i(sh_ocl_arvalid_i),
    .sh_ocl_araddr_i (sh_ocl_araddr_i),
    .ocl_sh_arready_o(ocl_sh_arready_o),
    .ocl_sh_rvalid_o (ocl_sh_rvalid_o),
    .ocl_sh_rdata_o  (ocl_sh_rdata_o),
    .ocl_sh_rresp_o  (ocl_sh_rresp_o),
    .sh_ocl_rready_i (sh_ocl_rready_i),
    .wr_req_o        (wr_req),
    .wr_addr_o       (wr_addr),
    .wr_data_o       (wr_data),
    .wr_strb_o       (wr_strb),
    .wr_ack_i        (wr_ack),
    .wr_resp_i       (wr_resp),
    .rd_req_o        (rd_req),
    .rd_addr_o       (rd_addr),
    .rd_ack_i        (rd_ack),
    .rd_data_i       (rd_data),
    .rd_resp_i       (rd_resp)
  );

  ocl_ctrl_regs u_ctrl_regs (
    .clk_main_a0(clk_main_a0),
    .ocl_rst_n_i(ocl_rst_n),
    .wr_req_i   (wr_req),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .wr_ack_o   (wr_ack),
    .wr_resp_o  (wr_resp),
    .rd_req_i   (rd_req),
    .rd_addr_i  (rd_addr),
    .rd_ack_o   (rd_ack),
    .rd_data_o  (rd_data),
    .rd_resp_o  (rd_resp)
  );

endmodule

//--- sim/tb_cl_fsb_tasks.svh
// AXI-lite host driver, compare tasks and directed tests
// for the shell control path testbench

`ifndef TB_CL_FSB_TASKS_SVH
`define TB_CL_FSB_TASKS_SVH

// --------------------------------------------------------------------------
// compare tasks
// --------------------------------------------------------------------------
task automatic check_data(input string what, input ocl_data_t got, input ocl_data_t exp);
  if (got !== exp)
  begin
    $display("Error at %0t ns: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
    report_fail();
  end
endtask

task automatic check_resp(input string what, input axil_resp_e got, input axil_resp_e exp);
  if (got !== exp)
  begin
    $display("Error at %0t ns: %s gave response %0d, expected %0d", $time, what, got, exp);
    report_fail();
  end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    report_fail();
  end
endtask

task automatic report_timeout(input string what, input int limit);
  $display("Timeout: %s did not arrive within %0d cycles", what, limit);
  report_fail();
endtask

// --------------------------------------------------------------------------
// host bus driver
// --------------------------------------------------------------------------
function automatic ocl_addr_t make_addr(input ocl_slot_e slot, input logic [11:0] offset);
  ocl_addr_u a;
  a.raw      = '0;
  a.f.slot   = slot;
  a.f.offset = offset;
  return a.raw;
endfunction

// scratch registers sit at word index 4 to 7 of slot 0
function automatic ocl_addr_t scratch_addr(input scratch_idx_t idx);
  return make_addr(SLOT_CTRL, 12'h010 + 12'(idx) * 12'd4);
endfunction

task automatic present_write(input ocl_addr_t addr, input ocl_data_t data, input ocl_strb_t strb);
  @(posedge clk_main_a0);
  awvalid <= 1'b1;
  awaddr  <= addr;
  wvalid  <= 1'b1;
  wdata   <= data;
  wstrb   <= strb;
endtask

task automatic accept_write();
  int cycles;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!(awready && wready))
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      report_timeout("awready and wready", TIMEOUT_CYCLES);
    @(negedge clk_main_a0);
  end
  @(posedge clk_main_a0);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
endtask

task automatic collect_bresp(output axil_resp_e resp);
  int cycles;
  @(posedge clk_main_a0);
  bready <= 1'b1;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!bvalid)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      report_timeout("bvalid", TIMEOUT_CYCLES);
    @(negedge clk_main_a0);
  end
  resp = bresp;
  @(posedge clk_main_a0);
  bready <= 1'b0;
endtask

task automatic axil_write(input ocl_addr_t addr, input ocl_data_t data, input ocl_strb_t strb,
                          output axil_resp_e resp);
  present_write(addr, data, strb);
  accept_write();
  collect_bresp(resp);
endtask

task automatic axil_read(input ocl_addr_t addr, output ocl_data_t data, output axil_resp_e resp);
  int cycles;
  @(posedge clk_main_a0);
  arvalid <= 1'b1;
  araddr  <= addr;
  rready  <= 1'b1;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!arready)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      report_timeout("arready", TIMEOUT_CYCLES);
    @(negedge clk_main_a0);
  end
  @(posedge clk_main_a0);
  arvalid <= 1'b0;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!rvalid)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      report_timeout("rvalid", TIMEOUT_CYCLES);
    @(negedge clk_main_a0);
  end
  data = rdata;
  resp = rresp;
  @(posedge clk_main_a0);
  rready <= 1'b0;
endtask

task automatic compare_scratch();
  ocl_data_t  data;
  axil_resp_e resp;
  for (int i = 0; i < 4; i++)
  begin
    axil_read(scratch_addr(scratch_idx_t'(i)), data, resp);
    check_data("scratch read back", data, scratch_model[i]);
    check_resp("scratch read back", resp, OKAY);
  end
endtask

// --------------------------------------------------------------------------
// directed tests
// --------------------------------------------------------------------------
task automatic check_idle_after_reset();
  @(negedge clk_main_a0);
  check_flag("awready after reset", awready, 1'b0);
  check_flag("wready after reset", wready, 1'b0);
  check_flag("arready after reset", arready, 1'b0);
  check_flag("bvalid after reset", bvalid, 1'b0);
  check_flag("rvalid after reset", rvalid, 1'b0);
  check_flag("cl_sh_flr_done after reset", flr_done, 1'b0);
endtask

task automatic test_id_words();
  ocl_data_t  data;
  axil_resp_e resp;
  check_data("cl_sh_id0_o", id0, `CL_SH_ID0);
  check_data("cl_sh_id1_o", id1, `CL_SH_ID1);
  axil_read(make_addr(SLOT_CTRL, 12'h000), data, resp);
  check_data("ID0 read", data, `CL_SH_ID0);
  check_resp("ID0 read", resp, OKAY);
  axil_read(make_addr(SLOT_CTRL, 12'h004), data, resp);
  check_data("ID1 read", data, `CL_SH_ID1);
  check_resp("ID1 read", resp, OKAY);
endtask

task automatic test_scratch_round_trip();
  ocl_data_t  data;
  ocl_strb_t  strb;
  axil_resp_e resp;
  for (int i = 0; i < 4; i++)
  begin
    data = lcg_next();
    axil_write(scratch_addr(scratch_idx_t'(i)), data, 4'hF, resp);
    check_resp("scratch full write", resp, OKAY);
    scratch_model[i] = data;
  end
  // only the strobed byte lanes change
  data = lcg_next();
  strb = 4'b0101;
  axil_write(scratch_addr(2), data, strb, resp);
  check_resp("scratch partial write", resp, OKAY);
  for (int b = 0; b < 4; b++)
    if (strb[b])
      scratch_model[2][8*b +: 8] = data[8*b +: 8];
  compare_scratch();
endtask

task automatic test_read_only_and_unmapped();
  ocl_data_t  data;
  axil_resp_e resp;
  axil_write(make_addr(SLOT_CTRL, 12'h000), lcg_next(), 4'hF, resp);
  check_resp("ID0 write", resp, OKAY);
  axil_read(make_addr(SLOT_CTRL, 12'h000), data, resp);
  check_data("ID0 read after write", data, `CL_SH_ID0);
  check_resp("ID0 read after write", resp, OKAY);
  axil_read(make_addr(SLOT_CTRL, 12'h020), data, resp);
  check_data("read at offset 0x020", data, '0);
  check_resp("read at offset 0x020", resp, SLVERR);
  axil_write(make_addr(SLOT_CTRL, 12'h020), lcg_next(), 4'hF, resp);
  check_resp("write at offset 0x020", resp, SLVERR);
  compare_scratch();
endtask

task automatic test_decode_error_slots();
  ocl_data_t  data;
  axil_resp_e resp;
  for (int s = 1; s < 4; s++)
  begin
    axil_write(make_addr(ocl_slot_e'(s), 12'h010), lcg_next(), 4'hF, resp);
    check_resp("write to unmapped slot", resp, DECERR);
    axil_read(make_addr(ocl_slot_e'(s), 12'h010), data, resp);
    check_resp("read from unmapped slot", resp, DECERR);
  end
  compare_scratch();
endtask

task automatic test_write_back_pressure();
  ocl_data_t  first;
  ocl_data_t  second;
  axil_resp_e resp;
  int         cycles;
  first  = lcg_next();
  second = lcg_next();
  present_write(scratch_addr(1), first, 4'hF);
  accept_write();
  // response waits while bready stays low
  cycles = 0;
  @(negedge clk_main_a0);
  while (!bvalid)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
      report_timeout("bvalid of the first write", TIMEOUT_CYCLES);
    @(negedge clk_main_a0);
  end
  present_write(scratch_addr(3), second, 4'hF);
  repeat (5)
  begin
    @(negedge clk_main_a0);
    check_flag("bvalid while bready low", bvalid, 1'b1);
    check_flag("awready while response pending", awready, 1'b0);
  end
  collect_bresp(resp);
  check_resp("first write under back-pressure", resp, OKAY);
  scratch_model[1] = first;
  accept_write();
  collect_bresp(resp);
  check_resp("second write under back-pressure", resp, OKAY);
  scratch_model[3] = second;
  compare_scratch();
endtask

task automatic test_flr_ack();
  int cycles;
  @(posedge clk_main_a0);
  flr_assert <= 1'b1;
  @(posedge clk_main_a0);
  flr_assert <= 1'b0;
  cycles = 0;
  @(negedge clk_main_a0);
  while (!flr_done)
  begin
    cycles++;
    if (cycles > 4)
      report_timeout("cl_sh_flr_done pulse", 4);
    @(negedge clk_main_a0);
  end
  // single pulse for a single-cycle assert
  repeat (3)
  begin
    @(negedge clk_main_a0);
    check_flag("cl_sh_flr_done after pulse", flr_done, 1'b0);
  end
endtask

`endif

//--- sim/tb_cl_fsb.sv
// Testbench for the shell control path
// Clock, reset, DUT, random word source and the directed test sequence

`timescale 1ns/1ns

`include "cl_fsb_settings.svh"

module tb_cl_fsb
  import ocl_bus_pkg::*;
  import cl_ctrl_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;

  logic        clk_main_a0;
  logic        pipe_rst_n;
  logic        flr_assert;
  logic        flr_done;
  logic [31:0] id0;
  logic [31:0] id1;
  logic        awvalid;
  ocl_addr_t   awaddr;
  logic        awready;
  logic        wvalid;
  ocl_data_t   wdata;
  ocl_strb_t   wstrb;
  logic        wready;
  logic        bvalid;
  axil_resp_e  bresp;
  logic        bready;
  logic        arvalid;
  ocl_addr_t   araddr;
  logic        arready;
  logic        rvalid;
  ocl_data_t   rdata;
  axil_resp_e  rresp;
  logic        rready;
  logic [31:0] lcg_state;
  // expected scratch contents
  ocl_data_t   scratch_model [4];

  always #10 clk_main_a0 = ~clk_main_a0;

  cl_fsb DUT (
    .clk_main_a0       (clk_main_a0),
    .pipe_rst_n        (pipe_rst_n),
    .sh_cl_flr_assert_i(flr_assert),
    .cl_sh_flr_done_o  (flr_done),
    .cl_sh_id0_o       (id0),
    .cl_sh_id1_o       (id1),
    .sh_ocl_awvalid_i  (awvalid),
    .sh_ocl_awaddr_i   (awaddr),
    .ocl_sh_awready_o  (awready),
    .sh_ocl_wvalid_i   (wvalid),
    .sh_ocl_wdata_i    (wdata),
    .sh_ocl_wstrb_i    (wstrb),
    .ocl_sh_wready_o   (wready),
    .ocl_sh_bvalid_o   (bvalid),
    .ocl_sh_bresp_o    (bresp),
    .sh_ocl_bready_i   (bready),
    .sh_ocl_arvalid_i  (arvalid),
    .sh_ocl_araddr_i   (araddr),
    .ocl_sh_arready_o  (arready),
    .ocl_sh_rvalid_o   (rvalid),
    .ocl_sh_rdata_o    (rdata),
    .ocl_sh_rresp_o    (rresp),
    .sh_ocl_rready_i   (rready)
  );

  // linear congruential generator
  function automatic ocl_data_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_fail();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  `include "tb_cl_fsb_tasks.svh"

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    lcg_state   = 32'd40;
    clk_main_a0 = 1'b0;
    pipe_rst_n  = 1'b0;
    flr_assert  = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    for (int i = 0; i < 4; i++)
      scratch_model[i] = '0;
    repeat (3) @(posedge clk_main_a0);
    pipe_rst_n <= 1'b1;
    // block reset comes out of the pipe and the synchronizer
    repeat (`RST_PIPE_STAGES + 4) @(posedge clk_main_a0);
    check_idle_after_reset();
    test_id_words();
    test_scratch_round_trip();
    test_read_only_and_unmapped();
    test_decode_error_slots();
    test_write_back_pressure();
    test_flr_ack();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+source
+incdir+sim
source/ocl_bus_pkg.sv
source/cl_ctrl_pkg.sv
source/cl_reset_ctrl.sv
source/ocl_slot_router.sv
source/ocl_ctrl_regs.sv
source/cl_fsb.sv
sim/tb_cl_fsb.sv

//--- Bender.yml
package:
  name: cl_fsb

sources:
  - include_dirs:
      - source
    files:
      - source/ocl_bus_pkg.sv
      - source/cl_ctrl_pkg.sv
      - source/cl_reset_ctrl.sv
      - source/ocl_slot_router.sv
      - source/ocl_ctrl_regs.sv
      - source/cl_fsb.sv

  - target: simulation
    include_dirs:
      - source
      - sim
    files:
      - sim/tb_cl_fsb.sv
